// File: src/pit_pkg.sv
package pit_pkg;

	// ========================================
	// bus geometry
	// ========================================

	// one data word per access, no byte lanes
	localparam int PIT_DW = 32;
	// word address, bits 7:2 pick the timer and bits 1:0 its register
	localparam int PIT_AW = 8;

	// ========================================
	// register map
	// ========================================

	// per-timer register selector, taken from adr_i[1:0]
	typedef enum logic [1:0] {
		treg_count  = 2'd0,
		treg_max    = 2'd1,
		treg_ontime = 2'd2,
		treg_ctrl   = 2'd3
	} pit_treg_e;

	// global registers live at word 128 and above
	typedef enum logic [7:0] {
		greg_underflow = 8'd128,
		greg_sync      = 8'd129,
		greg_ie        = 8'd130,
		greg_tmp       = 8'd131,
		greg_out       = 8'd132,
		greg_igate     = 8'd133
	} pit_greg_e;

	// ========================================
	// channel control and status
	// ========================================

	// control bits, ld sits in data bit 0 and ge in bit 4
	typedef struct packed {
		logic ge;
		logic xc;
		logic ar;
		logic ce;
		logic ld;
	} pit_ctrl_t;

	// control value after reset, auto-reload on and everything else off
	localparam pit_ctrl_t PIT_CTRL_RST = '{ge: 1'b0, xc: 1'b0, ar: 1'b1, ce: 1'b0, ld: 1'b0};

	// active configuration of one timer
	typedef struct packed {
		pit_ctrl_t         ctrl;
		logic [PIT_DW-1:0] maxcount;
		logic [PIT_DW-1:0] ontime;
	} pit_chan_cfg_t;

	// what a timer reports back, count zero extended to the bus width
	typedef struct packed {
		logic [PIT_DW-1:0] count;
		logic              out;
		logic              tc;
	} pit_chan_stat_t;

endpackage

// File: src/pit_edge_sync.sv
module pit_edge_sync (
	input  logic clk_i,
	input  logic rst_i,
	input  logic ext_clk_i,
	output logic tick_o
);

	// two flop synchronizer for the asynchronous pin
	logic sync1;
	logic sync2;
	// synchronized level one cycle ago
	logic prev;
	// registered rising edge
	logic tick_q;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			sync1  <= 1'b0;
			sync2  <= 1'b0;
			prev   <= 1'b0;
			tick_q <= 1'b0;
		end else begin
			sync1  <= ext_clk_i;
			sync2  <= sync1;
			prev   <= sync2;
			// rising edge of the synchronized level
			tick_q <= sync2 & ~prev;
		end
	end

	// one cycle wide, three cycles after the pin edge
	assign tick_o = tick_q;

endmodule

// File: src/pit_channel.sv
module pit_channel #(
	parameter int BITS = 16
) (
	input  logic                    clk_i,
	input  logic                    rst_i,
	input  pit_pkg::pit_chan_cfg_t  cfg_i,
	input  logic                    load_i,
	input  logic                    tick_i,
	input  logic                    gate_i,
	input  logic                    igate_i,
	output pit_pkg::pit_chan_stat_t stat_o
);

	import pit_pkg::*;

	// down counter and output level
	logic [BITS-1:0] count;
	logic            out_q;

	// count qualifiers
	logic clk_ok;
	logic gate_ok;
	logic en;

	// compare results on the value before the decrement
	logic at_zero;
	logic at_ontime;

	// ========================================
	// enable decision
	// ========================================

	always_comb begin
		// external clock mode counts only on a synchronized tick
		clk_ok  = cfg_i.ctrl.xc ? tick_i : 1'b1;
		// gated mode needs both the pin and the internal gate
		gate_ok = cfg_i.ctrl.ge ? (gate_i & igate_i) : 1'b1;
		en      = cfg_i.ctrl.ce & clk_ok & gate_ok;
	end

	assign at_zero   = (count == '0);
	// compare at bus width so stray upper on-time bits never match
	assign at_ontime = (PIT_DW'(count) == cfg_i.ontime);

	// ========================================
	// counter
	// ========================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			count <= '0;
			out_q <= 1'b0;
		end else if (load_i) begin
			// load pulse wins over counting
			count <= cfg_i.maxcount[BITS-1:0];
		end else if (en) begin
			if (at_zero) begin
				// terminal count, reload or park at all ones
				if (cfg_i.ctrl.ar) begin
					count <= cfg_i.maxcount[BITS-1:0];
				end else begin
					count <= '1;
				end
				out_q <= 1'b0;
			end else begin
				count <= count - 1'b1;
				// output rises when the on-time is reached
				if (at_ontime) begin
					out_q <= 1'b1;
				end
			end
		end
	end

	// ========================================
	// status back to the register block
	// ========================================

	always_comb begin
		stat_o.count = PIT_DW'(count);
		stat_o.out   = out_q;
		// tc is high only in the cycle that wraps the counter
		stat_o.tc    = en & ~load_i & at_zero;
	end

endmodule

// File: src/pit_regs.sv
module pit_regs #(
	parameter int NTIMER = 4,
	parameter int BITS   = 16
) (
	input  logic                                 clk_i,
	input  logic                                 rst_i,
	input  logic                                 cs_i,
	input  logic                                 cyc_i,
	input  logic                                 stb_i,
	input  logic                                 we_i,
	input  logic [pit_pkg::PIT_AW-1:0]           adr_i,
	input  logic [pit_pkg::PIT_DW-1:0]           dat_i,
	output logic                                 ack_o,
	output logic [pit_pkg::PIT_DW-1:0]           dat_o,
	output pit_pkg::pit_chan_cfg_t  [NTIMER-1:0] cfg_o,
	output logic [NTIMER-1:0]                    load_o,
	output logic [NTIMER-1:0]                    igate_o,
	input  pit_pkg::pit_chan_stat_t [NTIMER-1:0] stat_i,
	output logic                                 irq_o
);

	import pit_pkg::*;

	// holding values are cut to the counter width
	localparam logic [PIT_DW-1:0] VAL_MASK = PIT_DW'({BITS{1'b1}});

	// bus qualifiers
	logic valid;
	logic wr;
	logic rd_rdy;

	// address decode
	logic       glob_sel;
	logic [5:0] timer_sel;
	pit_treg_e  treg;
	pit_greg_e  greg;

	// holding copies, moved to cfg_o on commit or sync
	logic [PIT_DW-1:0] maxh [NTIMER];
	logic [PIT_DW-1:0] onth [NTIMER];
	pit_ctrl_t         ctrlh [NTIMER];

	// global registers
	logic [NTIMER-1:0] underflow;
	logic [NTIMER-1:0] ie;
	logic [NTIMER-1:0] irqf;
	logic [NTIMER-1:0] igate;
	logic [PIT_DW-1:0] tmp;

	logic [NTIMER-1:0] out_vec;
	logic [PIT_DW-1:0] rd_data;

	// ========================================
	// bus handshake and decode
	// ========================================

	assign valid     = cs_i & cyc_i & stb_i;
	assign wr        = valid & we_i;
	assign glob_sel  = adr_i[7];
	assign timer_sel = adr_i[7:2];
	assign treg      = pit_treg_e'(adr_i[1:0]);
	assign greg      = pit_greg_e'(adr_i);

	// reads need one cycle for the registered data
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rd_rdy <= 1'b0;
		end else begin
			rd_rdy <= valid & ~we_i;
		end
	end

	// writes are acknowledged at once
	assign ack_o = valid & (we_i | rd_rdy);

	// ========================================
	// register updates
	// ========================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int n = 0; n < NTIMER; n++) begin
				maxh[n]  <= '0;
				onth[n]  <= '0;
				ctrlh[n] <= PIT_CTRL_RST;
				cfg_o[n] <= '{ctrl: PIT_CTRL_RST, maxcount: '0, ontime: '0};
			end
			underflow <= '0;
			ie        <= '0;
			irqf      <= '0;
			igate     <= '0;
			tmp       <= '0;
		end else begin
			for (int n = 0; n < NTIMER; n++) begin
				// active ld is a single cycle pulse
				cfg_o[n].ctrl.ld <= 1'b0;

				// acknowledge an underflow, also drops its interrupt enable
				if (wr && greg == greg_underflow && dat_i[n]) begin
					underflow[n] <= 1'b0;
					irqf[n]      <= 1'b0;
					ie[n]        <= 1'b0;
				end

				// terminal count from the channel
				if (stat_i[n].tc) begin
					underflow[n] <= 1'b1;
					if (ie[n]) begin
						irqf[n] <= 1'b1;
					end
					// one-shot mode stops here
					if (!cfg_o[n].ctrl.ar) begin
						cfg_o[n].ctrl.ce <= 1'b0;
					end
				end

				// per-timer registers
				if (wr && !glob_sel && timer_sel == 6'(n)) begin
					case (treg)
						treg_max: maxh[n] <= dat_i & VAL_MASK;
						treg_ontime: onth[n] <= dat_i & VAL_MASK;
						treg_ctrl: begin
							ctrlh[n] <= pit_ctrl_t'(dat_i[4:0]);
							// bit 7 commits this timer right away
							if (dat_i[7]) begin
								cfg_o[n] <= '{ctrl: pit_ctrl_t'(dat_i[4:0]),
									maxcount: maxh[n], ontime: onth[n]};
							end
						end
						default: ;
					endcase
				end

				// sync write commits every selected timer in the same edge
				if (wr && greg == greg_sync && dat_i[n]) begin
					cfg_o[n] <= '{ctrl: ctrlh[n], maxcount: maxh[n], ontime: onth[n]};
					ctrlh[n].ld <= 1'b0;
				end
			end

			if (wr && greg == greg_ie) begin
				ie   <= dat_i[NTIMER-1:0];
				// a disabled timer keeps no pending interrupt
				irqf <= irqf & dat_i[NTIMER-1:0];
			end
			if (wr && greg == greg_tmp) begin
				tmp <= dat_i;
			end
			if (wr && greg == greg_igate) begin
				igate <= dat_i[NTIMER-1:0];
			end
		end
	end

	// ========================================
	// read path
	// ========================================

	always_comb begin
		for (int n = 0; n < NTIMER; n++) begin
			out_vec[n] = stat_i[n].out;
		end
	end

	always_comb begin
		rd_data = '0;
		if (glob_sel) begin
			case (greg)
				greg_underflow: rd_data = PIT_DW'(underflow);
				// write only
				greg_sync: rd_data = '0;
				greg_ie: rd_data = PIT_DW'(ie);
				greg_tmp: rd_data = tmp;
				greg_out: rd_data = PIT_DW'(out_vec);
				greg_igate: rd_data = PIT_DW'(igate);
				default: rd_data = '0;
			endcase
		end else if (timer_sel < NTIMER) begin
			case (treg)
				treg_count: rd_data = stat_i[timer_sel].count;
				treg_max: rd_data = cfg_o[timer_sel].maxcount;
				treg_ontime: rd_data = cfg_o[timer_sel].ontime;
				// ld is never visible
				treg_ctrl: rd_data = PIT_DW'({cfg_o[timer_sel].ctrl.ge,
					cfg_o[timer_sel].ctrl.xc, cfg_o[timer_sel].ctrl.ar,
					cfg_o[timer_sel].ctrl.ce, 1'b0});
				default: rd_data = '0;
			endcase
		end
	end

	// read data lines up with the delayed ack
	always_ff @(posedge clk_i) begin
		dat_o <= valid ? rd_data : '0;
	end

	// ========================================
	// per-timer outputs
	// ========================================

	always_comb begin
		for (int n = 0; n < NTIMER; n++) begin
			load_o[n] = cfg_o[n].ctrl.ld;
		end
	end

	assign igate_o = igate;
	// flags are registered, so irq follows tc by one cycle
	assign irq_o   = |irqf;

endmodule

// File: src/pit_top.sv
module pit_top #(
	parameter int NTIMER = 4,
	parameter int BITS   = 16
) (
	input  logic                       clk_i,
	input  logic                       rst_i,
	input  logic                       cs_i,
	input  logic                       cyc_i,
	input  logic                       stb_i,
	input  logic                       we_i,
	input  logic [pit_pkg::PIT_AW-1:0] adr_i,
	input  logic [pit_pkg::PIT_DW-1:0] dat_i,
	output logic                       ack_o,
	output logic [pit_pkg::PIT_DW-1:0] dat_o,
	input  logic [NTIMER-1:0]          ext_clk_i,
	input  logic [NTIMER-1:0]          ext_gate_i,
	output logic [NTIMER-1:0]          out_o,
	output logic                       irq_o
);

	import pit_pkg::*;

	// register block to channels
	pit_chan_cfg_t  [NTIMER-1:0] cfg;
	logic           [NTIMER-1:0] load;
	logic           [NTIMER-1:0] igate;
	// channels back to the register block
	pit_chan_stat_t [NTIMER-1:0] stat;
	// synchronized external clock edges
	logic           [NTIMER-1:0] tick;

	pit_regs #(
		.NTIMER(NTIMER),
		.BITS  (BITS)
	) u_regs (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.cs_i   (cs_i),
		.cyc_i  (cyc_i),
		.stb_i  (stb_i),
		.we_i   (we_i),
		.adr_i  (adr_i),
		.dat_i  (dat_i),
		.ack_o  (ack_o),
		.dat_o  (dat_o),
		.cfg_o  (cfg),
		.load_o (load),
		.igate_o(igate),
		.stat_i (stat),
		.irq_o  (irq_o)
	);

	// ========================================
	// one synchronizer and counter per timer
	// ========================================

	for (genvar g = 0; g < NTIMER; g++) begin : g_timer
		pit_edge_sync u_sync (
			.clk_i    (clk_i),
			.rst_i    (rst_i),
			.ext_clk_i(ext_clk_i[g]),
			.tick_o   (tick[g])
		);

		pit_channel #(
			.BITS(BITS)
		) u_chan (
			.clk_i  (clk_i),
			.rst_i  (rst_i),
			.cfg_i  (cfg[g]),
			.load_i (load[g]),
			.tick_i (tick[g]),
			.gate_i (ext_gate_i[g]),
			.igate_i(igate[g]),
			.stat_o (stat[g])
		);

		// output level straight to the pin
		assign out_o[g] = stat[g].out;
	end

endmodule

// File: testbench/pit_props.sv
module pit_props (
	input logic clk_i,
	input logic rst_i,
	input logic cs_i,
	input logic cyc_i,
	input logic stb_i,
	input logic we_i,
	input logic ack_i,
	input logic irq_i,
	input logic ie_any_i
);

	timeunit 1ns;
	timeprecision 1ps;

	// strobe qualified by chip select and cycle
	logic valid;
	// high once any property below has failed
	logic fail_seen = 1'b0;

	assign valid = cs_i & cyc_i & stb_i;

	// ========================================
	// bus handshake
	// ========================================

	// an ack needs a live strobe, a read ack also the strobe cycle before it
	a_ack_valid: assert property (@(posedge clk_i) disable iff (rst_i)
		ack_i |-> valid && (we_i || $past(valid && !we_i)))
		else begin
			fail_seen = 1'b1;
			$error("ack_o high without a valid bus access or too early on a read");
		end

	// first strobe cycle acks a write at once and a read not yet
	a_wr_ack: assert property (@(posedge clk_i) disable iff (rst_i)
		(valid && !$past(valid)) |-> (ack_i == we_i))
		else begin
			fail_seen = 1'b1;
			$error("write not acknowledged at once, or read acknowledged at once");
		end

	// ========================================
	// interrupt
	// ========================================

	// quiet for two cycles once reset drops
	a_irq_rst: assert property (@(posedge clk_i) $fell(rst_i) |-> !irq_i ##1 !irq_i)
		else begin
			fail_seen = 1'b1;
			$error("irq_o high right after reset");
		end

	// a rising irq needs an enabled timer one cycle earlier
	a_irq_ie: assert property (@(posedge clk_i) disable iff (rst_i)
		$rose(irq_i) |-> $past(ie_any_i))
		else begin
			fail_seen = 1'b1;
			$error("irq_o raised while no interrupt was enabled");
		end

endmodule

bind pit_regs pit_props u_props (
	.clk_i   (clk_i),
	.rst_i   (rst_i),
	.cs_i    (cs_i),
	.cyc_i   (cyc_i),
	.stb_i   (stb_i),
	.we_i    (we_i),
	.ack_i   (ack_o),
	.irq_i   (irq_o),
	.ie_any_i(|ie)
);

// File: testbench/pit_tb.sv
module pit_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import pit_pkg::*;

	localparam int NTIMER   = 4;
	localparam int BITS     = 16;
	// cycles allowed before an ack is overdue
	localparam int ACK_MAX  = 8;
	// external clock level held this many cycles
	localparam int EXT_HOLD = 4;

	logic              clk;
	logic              rst;
	logic              cs;
	logic              cyc;
	logic              stb;
	logic              we;
	logic [PIT_AW-1:0] adr;
	logic [PIT_DW-1:0] wdata;
	logic              ack;
	logic [PIT_DW-1:0] rdata;
	logic [NTIMER-1:0] ext_clk;
	logic [NTIMER-1:0] ext_gate;
	logic [NTIMER-1:0] out;
	logic              irq;

	pit_top #(
		.NTIMER(NTIMER),
		.BITS  (BITS)
	) u_dut (
		.clk_i     (clk),
		.rst_i     (rst),
		.cs_i      (cs),
		.cyc_i     (cyc),
		.stb_i     (stb),
		.we_i      (we),
		.adr_i     (adr),
		.dat_i     (wdata),
		.ack_o     (ack),
		.dat_o     (rdata),
		.ext_clk_i (ext_clk),
		.ext_gate_i(ext_gate),
		.out_o     (out),
		.irq_o     (irq)
	);

	// 20 ns period
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ========================================
	// failure and compare
	// ========================================

	task automatic stop_run();
		$display("Test failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	// bound bus and interrupt properties end the run at the next edge
	always @(posedge clk) begin
		if (u_dut.u_regs.u_props.fail_seen) begin
			$display("a bound bus or interrupt property failed");
			stop_run();
		end
	end

	task automatic check_data(input logic [PIT_AW-1:0] a, input logic [PIT_DW-1:0] got,
		input logic [PIT_DW-1:0] exp);
		if (got !== exp) begin
			$display("FAILED %0t ns: read of address %h gave %h, expected %h",
				$time, a, got, exp);
			stop_run();
		end
	endtask

	task automatic check_irq(input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAILED %0t ns: irq_o is %b, expected %b", $time, got, exp);
			stop_run();
		end
	endtask

	task automatic check_out(input logic [NTIMER-1:0] got, input logic [NTIMER-1:0] exp);
		if (got !== exp) begin
			$display("FAILED %0t ns: out_o is %b, expected %b", $time, got, exp);
			stop_run();
		end
	endtask

	// ========================================
	// bus and pin drivers
	// ========================================

	task automatic start_access(input logic [PIT_AW-1:0] a, input logic [PIT_DW-1:0] d,
		input logic w);
		@(posedge clk);
		cs    <= 1'b1;
		cyc   <= 1'b1;
		stb   <= 1'b1;
		we    <= w;
		adr   <= a;
		wdata <= d;
	endtask

	// returns at the edge where ack is seen, strobe dropped there
	task automatic finish_access(input logic [PIT_AW-1:0] a);
		int cycles;
		cycles = 0;
		@(posedge clk);
		while (!ack && cycles < ACK_MAX) begin
			@(posedge clk);
			cycles++;
		end
		if (!ack) begin
			$display("no acknowledge from the DUT for the access to address %h", a);
			stop_run();
		end
		cs  <= 1'b0;
		cyc <= 1'b0;
		stb <= 1'b0;
		we  <= 1'b0;
	endtask

	task automatic bus_write(input logic [PIT_AW-1:0] a, input logic [PIT_DW-1:0] d);
		start_access(a, d, 1'b1);
		finish_access(a);
	endtask

	task automatic bus_read(input logic [PIT_AW-1:0] a, output logic [PIT_DW-1:0] d);
		start_access(a, '0, 1'b0);
		finish_access(a);
		// dat_o is registered, still the acked value here
		d = rdata;
	endtask

	task automatic ext_pulses(input int t, input int n);
		repeat (n) begin
			@(posedge clk);
			ext_clk[t] <= 1'b1;
			repeat (EXT_HOLD) @(posedge clk);
			ext_clk[t] <= 1'b0;
			repeat (EXT_HOLD) @(posedge clk);
		end
	endtask

	// one line of the stimulus file
	task automatic run_command(input byte op, input logic [PIT_DW-1:0] a,
		input logic [PIT_DW-1:0] b);
		logic [PIT_DW-1:0] rd;
		case (op)
			"W": bus_write(PIT_AW'(a), b);
			"R": begin
				bus_read(PIT_AW'(a), rd);
				check_data(PIT_AW'(a), rd, b);
			end
			"I": repeat (a) @(posedge clk);
			"E": ext_pulses(int'(a), int'(b));
			"G": begin
				@(posedge clk);
				ext_gate[int'(a)] <= b[0];
			end
			// pin checks look one edge later so pending writes have landed
			"Q": begin
				@(posedge clk);
				check_irq(irq, a[0]);
			end
			"O": begin
				@(posedge clk);
				check_out(out, a[NTIMER-1:0]);
			end
			default: begin
				$display("unknown command %c in the stimulus file", op);
				stop_run();
			end
		endcase
	endtask

	// ========================================
	// main sequence
	// ========================================

	initial begin
		int                fd;
		int                nf;
		string             line;
		byte               op;
		logic [PIT_DW-1:0] a;
		logic [PIT_DW-1:0] b;

		rst      = 1'b1;
		cs       = 1'b0;
		cyc      = 1'b0;
		stb      = 1'b0;
		we       = 1'b0;
		adr      = '0;
		wdata    = '0;
		ext_clk  = '0;
		ext_gate = '0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;

		fd = $fopen("testbench/pit_testdata.txt", "r");
		if (fd == 0) begin
			$display("cannot open the stimulus file testbench/pit_testdata.txt");
			stop_run();
		end
		while (!$feof(fd)) begin
			nf = $fgets(line, fd);
			// skip blank and comment lines
			if (nf > 0 && line.len() > 1 && line[0] != "#") begin
				a  = '0;
				b  = '0;
				nf = $sscanf(line, "%c %h %h", op, a, b);
				run_command(op, a, b);
			end
		end
		$fclose(fd);
		if (u_dut.u_regs.u_props.fail_seen) begin
			$display("a bound bus or interrupt property failed");
			stop_run();
		end else begin
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule

// File: testbench/pit_testdata.txt
# op a b, hex fields: W adr data | R adr expected | I cycles | E timer pulses
# G timer level | Q irq | O out_o vector
# register readback, timer 0
R 01 00000000
W 01 00000064
W 02 00000010
R 01 00000000
R 02 00000000
W 03 00000084
R 01 00000064
R 02 00000010
R 03 00000004
W 82 00000005
R 82 00000005
W 83 a5a5a5a5
R 83 a5a5a5a5
W 85 00000003
R 85 00000003
W 82 00000000
W 85 00000000
# one-shot stop, timer 1
W 05 00000005
W 07 00000083
I 10
R 04 0000ffff
R 07 00000000
R 80 00000002
Q 0
# interrupt, timer 2
W 82 00000004
W 09 00000003
W 0b 00000083
I 10
Q 1
R 80 00000006
W 80 00000004
Q 0
R 80 00000002
R 82 00000000
# synchronized start and stop, timers 0 and 3
W 01 00000020
W 0d 00000020
W 03 00000007
W 0f 00000007
R 00 00000000
R 0c 00000000
W 81 00000009
W 03 00000004
W 0f 00000004
W 81 00000009
R 00 0000001b
R 0c 0000001b
# external clock and gating, timer 1
W 05 00000010
W 85 00000002
G 1 1
W 07 0000009f
E 1 5
G 1 0
E 1 3
R 04 0000000b
W 85 00000000
G 1 1
E 1 4
R 04 0000000b
# output waveform, timer 2
W 09 00000006
W 0a 00000002
W 0b 0000008f
E 2 4
O 0
E 2 1
O 4
E 2 1
O 4
E 2 1
O 0
R 08 00000006
E 2 4
O 0
E 2 1
O 4
Q 0

// File: verilog.f
src/pit_pkg.sv
src/pit_edge_sync.sv
src/pit_channel.sv
src/pit_regs.sv
src/pit_top.sv
testbench/pit_props.sv
testbench/pit_tb.sv
